// File: hw/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// request address width
`define MEM_ADDR_W 32

// word width seen by the core
`define MEM_DATA_W 32

// address bits decoded by the RAM, upper bits ignored
`define MEM_DEPTH_LOG2 12

`endif

// File: hw/memPkg.sv
package memPkg;

    // current job of the controller
    typedef enum logic [1:0] {
        Idle,
        RInst,
        RData,
        WData
    } memState;

    // data port opcode
    typedef enum logic {
        Load,
        Store
    } accessKind;

    // value is the byte count
    typedef enum logic [2:0] {
        LenByte = 3'd1,
        LenHalf = 3'd2,
        LenWord = 3'd4
    } accessLen;

    typedef enum logic [1:0] {
        OwnNone,
        OwnData,
        OwnInst
    } busOwner;

endpackage

// File: hw/memCtrl.sv
`timescale 1ns/1ps

module memCtrl
    import memPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ioBufferFull,
    input  logic            fetchEn,
    input  logic            dataEn,
    input  accessKind       dataKind,
    input  accessLen        dataLen,
    output logic            accept,
    output logic            acceptData,
    output logic [2:0]      stage,
    output logic            writeNow,
    output logic            capture,
    output logic            clearWord,
    output logic            stall,
    output logic            fetchDone,
    output logic            dataDone,
    output memPkg::busOwner busOwner
);

    memState  state;
    accessLen lenQ;
    logic     lastStage;

    assign stall = !rdy || ioBufferFull;

    // data port has priority over fetch
    assign accept     = (state == Idle) && (dataEn || fetchEn) && !stall;
    assign acceptData = dataEn;
    assign clearWord  = accept;

    assign writeNow = (state == WData);

    // stage 0 only issues the first address, nothing to capture yet
    assign capture = ((state == RData) || (state == RInst)) && (stage != 3'd0);

    always_comb begin
        case (state)
            RInst:   lastStage = (stage == 3'(LenWord));
            RData:   lastStage = (stage == 3'(lenQ));
            // stores finish on the cycle of the last write
            WData:   lastStage = (stage == 3'(lenQ) - 3'd1);
            default: lastStage = 1'b0;
        endcase
    end

    assign fetchDone = !stall && (state == RInst) && lastStage;
    assign dataDone  = !stall && ((state == RData) || (state == WData)) && lastStage;

    always_comb begin
        case (state)
            RInst:        busOwner = OwnInst;
            RData, WData: busOwner = OwnData;
            default:      busOwner = OwnNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            stage <= 3'd0;
            lenQ  <= LenByte;
        end else if (!stall) begin
            case (state)
                Idle: begin
                    if (accept) begin
                        stage <= 3'd0;
                        if (dataEn) begin
                            lenQ  <= dataLen;
                            state <= (dataKind == Store) ? WData : RData;
                        end else begin
                            state <= RInst;
                        end
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= Idle;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // a data request entering arbitration carries a legal length
    legalLenA: assert property (
        @(posedge clk) disable iff (rst)
        (state == Idle && dataEn) |-> (dataLen inside {LenByte, LenHalf, LenWord})
    );

    // each done is a single pulse that hands the RAM back
    oneDoneA: assert property (
        @(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> (state == Idle) && !(fetchDone || dataDone)
    );

    // back-pressure freezes the job so its done waits
    noDoneStallA: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(state) && $stable(stage)
    );

endmodule

// File: hw/readAssembler.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module readAssembler
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  logic                   clearWord,
    input  logic [2:0]             stage,
    input  logic                   stall,
    input  logic [7:0]             ramDout,
    output logic [`MEM_DATA_W-1:0] word
);

    // lanes 0..2, lane 3 only ever comes from the live byte
    logic [2:0][7:0] lanes;
    logic [1:0]      lane;

    // stage 1..4 maps to lane 0..3
    assign lane = stage[1:0] - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            lanes <= '0;
        end else if (!stall) begin
            if (clearWord) begin
                lanes <= '0;
            end else if (capture && (stage != 3'(LenWord))) begin
                lanes[lane] <= ramDout;
            end
        end
    end

    // untouched upper lanes stay zero, giving the zero-extension
    always_comb begin
        word = {8'h00, lanes};
        if (capture) begin
            word[{lane, 3'b000} +: 8] = ramDout;
        end
    end

endmodule

// File: hw/ramBusDriver.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module ramBusDriver
    import memPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       accept,
    input  logic                       acceptData,
    input  logic [2:0]                 stage,
    input  logic                       writeNow,
    input  logic                       stall,
    input  logic [`MEM_ADDR_W-1:0]     fetchAddr,
    input  logic [`MEM_ADDR_W-1:0]     dataAddr,
    input  logic [`MEM_DATA_W-1:0]     dataWdata,
    output logic [`MEM_DEPTH_LOG2-1:0] ramAddr,
    output logic                       ramWe,
    output logic [7:0]                 ramDin
);

    logic [`MEM_DEPTH_LOG2-1:0] baseAddr;
    logic [`MEM_DATA_W-1:0]     storeWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr <= '0;
        end else if (accept && !stall) begin
            baseAddr <= acceptData ? dataAddr[`MEM_DEPTH_LOG2-1:0]
                                   : fetchAddr[`MEM_DEPTH_LOG2-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !stall) begin
            storeWord <= dataWdata;
        end
    end

    // wraps inside the RAM
    // under stall the previous byte is re-read so the RAM output holds
    assign ramAddr = baseAddr + {{(`MEM_DEPTH_LOG2 - 3){1'b0}}, stage}
                     - {{(`MEM_DEPTH_LOG2 - 1){1'b0}}, stall};

    assign ramWe = writeNow && !stall;

    // little endian, byte k goes out in stage k
    always_comb begin
        if (stage < 3'(LenWord)) begin
            ramDin = storeWord[{stage[1:0], 3'b000} +: 8];
        end else begin
            ramDin = 8'h00;
        end
    end

endmodule

// File: hw/byteRam.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module byteRam (
    input  logic                       clk,
    input  logic [`MEM_DEPTH_LOG2-1:0] ramAddr,
    input  logic                       ramWe,
    input  logic [7:0]                 ramDin,
    output logic [7:0]                 ramDout
);

    localparam int Depth = 1 << `MEM_DEPTH_LOG2;

    logic [7:0] mem [0:Depth-1];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramDin;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        ramDout <= mem[ramAddr];
    end

endmodule

// File: hw/memSubsystem.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module memSubsystem
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,
    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  accessKind              dataKind,
    input  accessLen               dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  logic [`MEM_DATA_W-1:0] dataWdata,
    output logic                   fetchDone,
    output logic [`MEM_DATA_W-1:0] fetchInst,
    output logic                   dataDone,
    output logic [`MEM_DATA_W-1:0] dataRdata,
    output memPkg::busOwner        busOwner
);

    logic                       accept;
    logic                       acceptData;
    logic [2:0]                 stage;
    logic                       writeNow;
    logic                       capture;
    logic                       clearWord;
    logic                       stall;
    logic [`MEM_DEPTH_LOG2-1:0] ramAddr;
    logic                       ramWe;
    logic [7:0]                 ramDin;
    logic [7:0]                 ramDout;
    logic [`MEM_DATA_W-1:0]     word;

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .dataKind     (dataKind),
        .dataLen      (dataLen),
        .accept       (accept),
        .acceptData   (acceptData),
        .stage        (stage),
        .writeNow     (writeNow),
        .capture      (capture),
        .clearWord    (clearWord),
        .stall        (stall),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .busOwner     (busOwner)
    );

    ramBusDriver busDriver (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .acceptData (acceptData),
        .stage      (stage),
        .writeNow   (writeNow),
        .stall      (stall),
        .fetchAddr  (fetchAddr),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramDin     (ramDin)
    );

    readAssembler assembler (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .clearWord (clearWord),
        .stage     (stage),
        .stall     (stall),
        .ramDout   (ramDout),
        .word      (word)
    );

    byteRam ram (
        .clk     (clk),
        .ramAddr (ramAddr),
        .ramWe   (ramWe),
        .ramDin  (ramDin),
        .ramDout (ramDout)
    );

    // one assembled word serves both ports
    assign fetchInst = word;
    assign dataRdata = word;

endmodule

// File: sim/memSubsystemTb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module memSubsystemTb
    import memPkg::*;
();

    logic                   clk, rst, rdy, ioBufferFull;
    logic                   fetchEn, dataEn, fetchDone, dataDone;
    logic [`MEM_ADDR_W-1:0] fetchAddr, dataAddr;
    logic [`MEM_DATA_W-1:0] dataWdata, fetchInst, dataRdata;
    accessKind              dataKind;
    accessLen               dataLen;
    busOwner                owner;

    // reference copy of the 256-byte test window
    logic [7:0]  shadow [0:255];
    integer      seed;
    int          checks;
    int          errors;
    bit          stallOn;
    // job in flight, as seen by the done monitor
    accessKind   curKind;
    accessLen    curLen;
    logic [7:0]  curAddr;
    logic [7:0]  curFetch;
    logic [31:0] curWdata;

    memSubsystem DUT (.busOwner(owner), .*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random back-pressure spans from either stall source
    initial begin
        integer      stallSeed;
        logic [31:0] r;
        stallSeed = 32'he8af;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            @(posedge clk);
            r = $random(stallSeed);
            if (stallOn && r[2:0] == 3'd0) begin
                rdy <= r[3];
                ioBufferFull <= r[3];
                repeat (1 + r[5:4]) @(posedge clk);
                rdy <= 1'b1;
                ioBufferFull <= 1'b0;
            end
        end
    end

    // zero-extended little-endian value from the shadow memory
    function automatic logic [31:0] refRead(input logic [7:0] addr, input accessLen len);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < int'(len); i++) begin
            value[8*i +: 8] = shadow[addr + 8'(i)];
        end
        return value;
    endfunction

    function automatic accessLen pickLen(input logic [1:0] sel);
        return (sel == 2'd0) ? LenByte : (sel == 2'd1) ? LenHalf : LenWord;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // compares every completed job, stores update the shadow at their done pulse
    initial begin
        int i;
        forever begin
            @(posedge clk);
            if (!rst && fetchDone && dataDone) begin
                errors++;
                $display("fetchDone and dataDone were high in the same cycle");
            end
            if (!rst && (fetchDone || dataDone) && (!rdy || ioBufferFull)) begin
                errors++;
                $display("a done pulse was high while the subsystem was stalled");
            end
            if (!rst && dataDone && curKind == Load) begin
                checkValue("dataRdata", refRead(curAddr, curLen), dataRdata);
            end
            if (!rst && dataDone && curKind == Store) begin
                for (i = 0; i < int'(curLen); i++) begin
                    shadow[curAddr + 8'(i)] = curWdata[8*i +: 8];
                end
            end
            if (!rst && fetchDone) begin
                checkValue("fetchInst", refRead(curFetch, LenWord), fetchInst);
            end
        end
    end

    // r[7:0] and r[15:8] pick the data and fetch addresses inside the window
    task automatic runJob(input bit doData, input bit doFetch, input accessKind kind,
                          input accessLen len, input logic [31:0] r, input bit timed);
        int      cycles;
        bit      gotData;
        bit      gotFetch;
        busOwner job;
        cycles = 0;
        gotData = !doData;
        gotFetch = !doFetch;
        job = doData ? OwnData : OwnInst;
        @(posedge clk);
        curKind = kind;
        curLen = len;
        curAddr = 8'({1'b0, r[7:0]} % (9'd257 - 9'(len)));
        curFetch = 8'(r[15:8] % 8'd253);
        curWdata = $random(seed);
        dataKind <= kind;
        dataLen <= len;
        dataAddr <= 32'(curAddr);
        dataWdata <= curWdata;
        fetchAddr <= 32'(curFetch);
        dataEn <= doData;
        fetchEn <= doFetch;
        do begin
            @(posedge clk);
            cycles++;
            if (fetchDone && !gotData) begin
                errors++;
                $display("fetchDone came before dataDone");
            end
            if (timed && cycles > 1 && !(dataDone || fetchDone)) begin
                checkValue("busOwner", 32'(job), 32'(owner));
            end
            if (dataDone) begin
                dataEn <= 1'b0;
            end
            if (fetchDone) begin
                fetchEn <= 1'b0;
            end
            gotData |= dataDone;
            gotFetch |= fetchDone;
        end while (!(gotData && gotFetch) && cycles < 200);
        if (!(gotData && gotFetch)) begin
            errors++;
            $display("timeout after %0d cycles waiting for a done pulse", cycles);
            dataEn <= 1'b0;
            fetchEn <= 1'b0;
        end else if (timed) begin
            checkValue("done latency",
                       doFetch ? 5 : ((kind == Load) ? int'(len) + 1 : int'(len)), cycles - 1);
        end
        @(posedge clk);
        if (timed) begin
            checkValue("busOwner", 32'(OwnNone), 32'(owner));
        end
    endtask

    task automatic randomBatch(input int count, input bit doData, input bit doFetch,
                               input bit timed);
        logic [31:0] r;
        repeat (count) begin
            r = $random(seed);
            runJob(doData, doFetch, r[16] ? Store : Load, pickLen(r[18:17]), r, timed);
        end
    endtask

    task automatic sweepWords(input accessKind kind);
        int a;
        for (a = 0; a < 256; a += 4) begin
            runJob(1'b1, 1'b0, kind, LenWord, a, 1'b0);
        end
    endtask

    initial begin
        int mark;
        seed = 32'he8af;
        checks = 0;
        errors = 0;
        stallOn = 1'b0;
        rst = 1'b1;
        fetchEn = 1'b0;
        dataEn = 1'b0;
        fetchAddr = '0;
        dataAddr = '0;
        dataKind = Load;
        dataLen = LenWord;
        dataWdata = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        mark = errors;
        sweepWords(Store);
        sweepWords(Load);
        $display("test 1 word stores then word loads: %0d errors", errors - mark);
        mark = errors;
        randomBatch(200, 1'b1, 1'b0, 1'b0);
        $display("test 2 mixed-length access: %0d errors", errors - mark);
        mark = errors;
        randomBatch(20, 1'b0, 1'b1, 1'b1);
        $display("test 3 fetch: %0d errors", errors - mark);
        mark = errors;
        randomBatch(20, 1'b1, 1'b1, 1'b0);
        $display("test 4 arbitration: %0d errors", errors - mark);

        // loads, stores and fetches under back-pressure, then a full readback
        mark = errors;
        stallOn <= 1'b1;
        randomBatch(80, 1'b1, 1'b0, 1'b0);
        randomBatch(20, 1'b0, 1'b1, 1'b0);
        randomBatch(20, 1'b1, 1'b1, 1'b0);
        stallOn <= 1'b0;
        sweepWords(Load);
        $display("test 5 stall: %0d errors", errors - mark);
        mark = errors;
        randomBatch(40, 1'b1, 1'b0, 1'b1);
        randomBatch(10, 1'b0, 1'b1, 1'b1);
        $display("test 6 latency without stalls: %0d errors", errors - mark);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/memPkg.sv
hw/memCtrl.sv
hw/readAssembler.sv
hw/ramBusDriver.sv
hw/byteRam.sv
hw/memSubsystem.sv
sim/memSubsystemTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module memSubsystemTb -f list.f -o simv &&
    ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log 2>/dev/null && echo "run passed" ||
    { echo "run failed"; exit 1; }
